// ==== sim.f ====
+incdir+testbench
common/mmr_pkg.sv
design/mmr_cfg_chain.sv
cpsa_regs/cpsa_regs.sv
cpsb_regs/cpsb_regs.sv
design/video_mmr.sv
testbench/tb_video_mmr.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the register subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f sim.f \
    --top-module tb_video_mmr \
    -Mdir obj_dir \
    -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Test OK"; then
    exit 0
else
    echo "pass message not found"
    exit 1
fi

// ==== testbench/tb_mmr_ref.svh ====
`ifndef TB_MMR_REF_SVH
`define TB_MMR_REF_SVH

// word address held by a chain address byte, bits 5:1 of the byte address
function automatic logic [4:0] ref_word_addr(input logic [7:0] b);
    return b[5:1];
endfunction

// slots 1..4 and 6..9 go off at all ones, the input ports at zero
function automatic bit ref_slot_active(input int s, input logic [4:0] a);
    if ((s >= 1 && s <= 4) || (s >= 6 && s <= 9))
        return a != 5'h1f;
    if (s == 10 || s == 11)
        return a != 5'h00;
    return 1'b1;
endfunction

// slot picked by a read, -1 when the read returns the idle word
function automatic int ref_decode(input logic [4:0] a);
    int lo_n;
    int hi_n;
    int lo_s;
    int hi_s;
    lo_n = 0;
    hi_n = 0;
    lo_s = -1;
    hi_s = -1;
    if (&a)
        return -1;
    for (int i = 0; i < 13; i++) begin
        if (prog_addr[i] == a && ref_slot_active(i, prog_addr[i])) begin
            if (i < 6) begin
                lo_n++;
                lo_s = i;
            end else begin
                hi_n++;
                hi_s = i;
            end
        end
    end
    if (lo_n == 1)
        return lo_s;
    if (hi_n == 1)
        return hi_s;
    return -1;
endfunction

function automatic logic [15:0] ref_id_word(input logic [7:0] id);
    return {4'd0, id[7:4], 4'd0, id[3:0]};
endfunction

function automatic logic [31:0] ref_product(input logic [15:0] a, input logic [15:0] b);
    return {16'd0, a} * {16'd0, b};
endfunction

function automatic logic [7:0] ref_in2(input bit six, input logic [3:0] st, input logic [3:0] cn,
                                      input logic [9:0] j1, input logic [9:0] j2,
                                      input logic [9:0] j3);
    if (six)
        return {1'b1, j2[9:7], 1'b1, j1[9:7]};   // extra buttons of players 2 and 1
    return {st[2], cn[2], j3[5:0]};
endfunction

function automatic logic [7:0] ref_in3(input logic [3:0] st, input logic [3:0] cn,
                                      input logic [9:0] j4);
    return {st[3], cn[3], j4[5:0]};
endfunction

`endif

// ==== testbench/tb_video_mmr.sv ====
module tb_video_mmr import mmr_pkg::*; ();

    localparam int RUN_CYCLES = 16 + 3 * (CFG_BYTES * 3 + 8) + 36 * 2 + 60 + 40 * 3 + 60;

    logic clk, reg_rst, pxl_cen, cfg_we, ppu1_cs, ppu2_cs;
    logic [7:0]  cfg_data;
    logic [4:0]  addr;
    logic [1:0]  dsn;
    logic [15:0] cpu_dout, mmr_dout;
    logic [3:0]  start_button, coin_input;
    logic [9:0]  joystick1, joystick2, joystick3, joystick4;
    logic [15:0] vram_obj_base, vram1_base, vram2_base, vram3_base, vram_row_base, pal_base;
    logic [15:0] hpos1, hpos2, hpos3, vpos1, vpos2, vpos3;
    logic [15:0] hstar1, hstar2, vstar1, vstar2, row_offset, ppu_ctrl;
    logic        pal_copy, obj_dma_ok, cpu_speed, charger, kabuki_en;
    layer_ctrl_u layer_ctrl;
    logic [15:0] prio0, prio1, prio2, prio3, bank_offset, bank_mask;
    logic [5:0]  pal_page_en;
    logic [7:0]  layer_mask0, layer_mask1, layer_mask2, layer_mask3, game;

    logic [15:0] lfsr;
    logic [1:0]  cen_cnt;
    logic [7:0]  cfg [CFG_BYTES];
    logic [4:0]  prog_addr [13];   // slot order follows the chain
    logic [15:0] exp_a [18];
    logic [15:0] m_mult1, m_mult2, m_layer, m_prio [4];
    logic [5:0]  m_pal;

    `include "tb_mmr_ref.svh"

    video_mmr dut (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // pixel enable every fourth cycle
    always @(negedge clk) begin
        pxl_cen = (cen_cnt == 2'd3);
        cen_cnt = cen_cnt + 2'd1;
    end

    initial begin
        #(RUN_CYCLES * 8 * 2);
        $display("watchdog: the run took longer than the tests need, stopping");
        $display("Test FAILED");
        $fatal(1);
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);  // galois step
        end
        return v;
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED time=%0t %s got=%h expected=%h", $time, name, got, exp);
            fail_now("value mismatch");
        end
    endtask

    function automatic logic [15:0] cpsa_out(input int idx);
        case (idx)
            0: return vram_obj_base;
            1: return vram1_base;
            2: return vram2_base;
            3: return vram3_base;
            4: return vram_row_base;
            5: return pal_base;
            6: return hpos1;
            7: return vpos1;
            8: return hpos2;
            9: return vpos2;
            10: return hpos3;
            11: return vpos3;
            12: return hstar1;
            13: return vstar1;
            14: return hstar2;
            15: return vstar2;
            16: return row_offset;
            default: return ppu_ctrl;
        endcase
    endfunction

    // expected readback from the model state
    function automatic logic [15:0] ref_read(input logic [4:0] a);
        logic [31:0] p;
        logic [7:0]  i2;
        logic [7:0]  i3;
        p = ref_product(m_mult1, m_mult2);
        i2 = ref_in2(cfg[CFG_FLAGS][3], start_button, coin_input, joystick1, joystick2,
                     joystick3);
        i3 = ref_in3(start_button, coin_input, joystick4);
        case (ref_decode(a))
            0: return ref_id_word(cfg[CFG_ID]);
            1: return m_mult1;
            2: return m_mult2;
            3: return p[15:0];
            4: return p[31:16];
            5: return m_layer;
            6, 7, 8, 9: return m_prio[ref_decode(a) - 6];
            10: return {i2, i2};
            11: return {i3, i3};
            12: return {10'd0, m_pal};
            default: return READ_IDLE;
        endcase
    endfunction

    task automatic cfg_send(input logic [7:0] b, input int hold);
        @(negedge clk);
        cfg_data = b;
        cfg_we = 1'b1;
        repeat (hold) @(negedge clk);
        cfg_we = 1'b0;
        @(negedge clk);
    endtask

    task automatic load_config();
        for (int i = 0; i < CFG_BYTES; i++)
            cfg_send(cfg[i], (i == CFG_BYTES - 1) ? 4 : 1);   // last byte held high
        for (int s = 0; s < 13; s++)
            prog_addr[s] = ref_word_addr(cfg[(s == 0) ? 0 : s + 1]);
        check_value("game", 32'(game), 32'(cfg[CFG_GAME]));
        check_value("bank_offset", 32'(bank_offset), {16'd0, cfg[20], cfg[19]});
        check_value("bank_mask", 32'(bank_mask), {16'd0, cfg[22], cfg[21]});
        check_value("cpu_speed", 32'(cpu_speed), 32'(cfg[CFG_FLAGS][0]));
        check_value("charger", 32'(charger), 32'(cfg[CFG_FLAGS][4]));
        check_value("kabuki_en", 32'(kabuki_en), 32'(cfg[CFG_FLAGS][5]));
        check_value("layer_mask0", 32'(layer_mask0), 32'(cfg[CFG_MASK0]));
        check_value("layer_mask1", 32'(layer_mask1), 32'(cfg[CFG_MASK1]));
        check_value("layer_mask2", 32'(layer_mask2), 32'(cfg[CFG_MASK2]));
        check_value("layer_mask3", 32'(layer_mask3), 32'(cfg[CFG_MASK3]));
    endtask

    task automatic bus_write(input bit chip2, input logic [4:0] a, input logic [15:0] d,
                             input logic [1:0] ds);
        @(negedge clk);
        ppu1_cs = !chip2;
        ppu2_cs = chip2;
        addr = a;
        dsn = ds;
        cpu_dout = d;
        @(negedge clk);
        ppu1_cs = 1'b0;
        ppu2_cs = 1'b0;
        dsn = 2'b11;
    endtask

    task automatic read_check(input logic [4:0] a, input string name);
        @(negedge clk);
        ppu2_cs = 1'b1;
        addr = a;
        dsn = 2'b11;
        @(negedge clk);
        ppu2_cs = 1'b0;
        check_value(name, 32'(mmr_dout), 32'(ref_read(a)));
    endtask

    initial begin
        int n;
        int high;
        logic [31:0] r;
        lfsr = 16'd69;
        cen_cnt = 2'd0;
        pxl_cen = 1'b0;
        reg_rst = 1'b1;
        cfg_we = 1'b0;
        cfg_data = '0;
        ppu1_cs = 1'b0;
        ppu2_cs = 1'b0;
        addr = '0;
        dsn = 2'b11;
        cpu_dout = '0;
        start_button = '0;
        coin_input = '0;
        joystick1 = '0;
        joystick2 = '0;
        joystick3 = '0;
        joystick4 = '0;
        repeat (16) @(negedge clk);
        reg_rst = 1'b0;
        @(negedge clk);
        check_value("mmr_dout", 32'(mmr_dout), 32'(READ_IDLE));
        check_value("layer_ctrl", 32'(layer_ctrl.raw), 32'(LAYER_CTRL_RST));
        check_value("pal_page_en", 32'(pal_page_en), 32'(PAL_PAGE_RST));
        check_value("pal_copy", 32'(pal_copy), 32'd0);
        check_value("obj_dma_ok", 32'(obj_dma_ok), 32'd0);

        // legal map, words 1..13 in chain order with random spare bits
        for (int i = 0; i < CFG_BYTES; i++)
            cfg[i] = 8'(rand_bits(8));
        for (int s = 0; s < 13; s++) begin
            r = rand_bits(3);
            cfg[(s == 0) ? 0 : s + 1] = {r[1:0], 5'(s + 1), r[2]};
        end
        // in2 parked on its disable word, in3 on the all-ones word
        cfg[CFG_ADDR_IN2] = {2'b00, ADDR_DISABLED_LO, 1'b0};
        cfg[CFG_ADDR_IN3] = {2'b00, 5'h1f, 1'b0};
        cfg[CFG_FLAGS][3] = 1'b0;
        load_config();

        for (int i = 0; i < 18; i++) begin
            exp_a[i] = 16'(rand_bits(16));
            bus_write(1'b0, 5'(i), exp_a[i], 2'b00);
            check_value("cpsa full write", 32'(cpsa_out(i)), 32'(exp_a[i]));
            bus_write(1'b0, 5'(i), ~exp_a[i], 2'b01);
            check_value("cpsa partial write", 32'(cpsa_out(i)), 32'(exp_a[i]));
        end
        repeat (10) @(negedge clk);     // earlier arms drain out

        @(negedge clk);
        ppu1_cs = 1'b1;
        addr = CPSA_PAL_BASE;
        dsn = 2'b00;
        cpu_dout = 16'(rand_bits(16));
        @(negedge clk);
        addr = CPSA_OBJ_BASE;
        cpu_dout = 16'(rand_bits(16));
        @(negedge clk);
        dsn = 2'b11;
        repeat (8) begin
            @(negedge clk);
            check_value("pal_copy", 32'(pal_copy), 32'd0);
            check_value("obj_dma_ok", 32'(obj_dma_ok), 32'd0);
        end
        ppu1_cs = 1'b0;
        n = 0;
        while (!pal_copy) begin
            @(negedge clk);
            n++;
            if (n > 20)
                fail_now("pal_copy never rose after the chip select dropped");
        end
        check_value("obj_dma_ok", 32'(obj_dma_ok), 32'd1);
        high = 0;
        while (pal_copy) begin
            high++;
            @(negedge clk);
            if (high > 10)
                fail_now("pal_copy stuck high");
        end
        check_value("pal_copy width", 32'(high), 32'd4);
        check_value("obj_dma_ok", 32'(obj_dma_ok), 32'd0);

        m_mult1 = 16'(rand_bits(16));
        m_mult2 = 16'(rand_bits(16));
        bus_write(1'b1, prog_addr[1], m_mult1, 2'b00);
        bus_write(1'b1, prog_addr[2], m_mult2, 2'b00);
        read_check(prog_addr[3], "rslt0");
        read_check(prog_addr[4], "rslt1");
        read_check(prog_addr[1], "mult1");
        for (int k = 0; k < 4; k++) begin
            m_prio[k] = 16'(rand_bits(16));
            bus_write(1'b1, prog_addr[6 + k], m_prio[k], 2'b00);
            read_check(prog_addr[6 + k], "prio");
        end
        check_value("prio0", 32'(prio0), 32'(m_prio[0]));
        check_value("prio1", 32'(prio1), 32'(m_prio[1]));
        check_value("prio2", 32'(prio2), 32'(m_prio[2]));
        check_value("prio3", 32'(prio3), 32'(m_prio[3]));
        m_layer = 16'(rand_bits(16));
        bus_write(1'b1, prog_addr[5], m_layer, 2'b00);
        read_check(prog_addr[5], "layer_ctrl readback");
        check_value("layer_ctrl enable", 32'(layer_ctrl.f.enable), 32'(m_layer[5:0]));
        m_pal = 6'(rand_bits(6));
        bus_write(1'b1, prog_addr[12], {10'd0, m_pal}, 2'b00);
        read_check(prog_addr[12], "pal_page_en readback");
        check_value("pal_page_en", 32'(pal_page_en), 32'(m_pal));
        read_check(prog_addr[0], "id");
        read_check(5'h1f, "forbidden address");
        read_check(5'h00, "disabled input port");
        read_check(5'h14, "unmapped address");

        // input ports back on words 11 and 12
        cfg[CFG_ADDR_IN2] = {2'b00, 5'd11, 1'b0};
        cfg[CFG_ADDR_IN3] = {2'b00, 5'd12, 1'b0};
        for (int mode = 1; mode >= 0; mode--) begin
            @(negedge clk);
            r = rand_bits(32);
            start_button = r[3:0];
            coin_input = r[7:4];
            joystick1 = r[17:8];
            joystick2 = r[27:18];
            r = rand_bits(20);
            joystick3 = r[9:0];
            joystick4 = r[19:10];
            cfg[CFG_FLAGS][3] = mode[0];
            load_config();
            repeat (3) @(negedge clk);
            read_check(prog_addr[10], "in2");
            read_check(prog_addr[11], "in3");
        end

        $display("Test OK");
        $finish;
    end

endmodule

// ==== design/video_mmr.sv ====
module video_mmr import mmr_pkg::*; (
    input  logic        clk,
    input  logic        reg_rst,
    input  logic        pxl_cen,
    input  logic        cfg_we,
    input  logic [7:0]  cfg_data,
    input  logic        ppu1_cs,
    input  logic        ppu2_cs,
    input  logic [4:0]  addr,
    input  logic [1:0]  dsn,
    input  logic [15:0] cpu_dout,
    output logic [15:0] mmr_dout,
    input  logic [3:0]  start_button,
    input  logic [3:0]  coin_input,
    input  logic [9:0]  joystick1,
    input  logic [9:0]  joystick2,
    input  logic [9:0]  joystick3,
    input  logic [9:0]  joystick4,
    output logic [15:0] vram_obj_base,
    output logic [15:0] vram1_base,
    output logic [15:0] vram2_base,
    output logic [15:0] vram3_base,
    output logic [15:0] vram_row_base,
    output logic [15:0] pal_base,
    output logic [15:0] hpos1,
    output logic [15:0] hpos2,
    output logic [15:0] hpos3,
    output logic [15:0] vpos1,
    output logic [15:0] vpos2,
    output logic [15:0] vpos3,
    output logic [15:0] hstar1,
    output logic [15:0] hstar2,
    output logic [15:0] vstar1,
    output logic [15:0] vstar2,
    output logic [15:0] row_offset,
    output logic [15:0] ppu_ctrl,
    output logic        pal_copy,
    output logic        obj_dma_ok,
    output layer_ctrl_u layer_ctrl,
    output logic [15:0] prio0,
    output logic [15:0] prio1,
    output logic [15:0] prio2,
    output logic [15:0] prio3,
    output logic [5:0]  pal_page_en,
    output logic [7:0]  layer_mask0,
    output logic [7:0]  layer_mask1,
    output logic [7:0]  layer_mask2,
    output logic [7:0]  layer_mask3,
    output logic [7:0]  game,
    output logic [15:0] bank_offset,
    output logic [15:0] bank_mask,
    output logic        cpu_speed,
    output logic        charger,
    output logic        kabuki_en
);

    // programmed map from the chain
    logic [4:0] addr_id;
    logic [4:0] addr_mult1;
    logic [4:0] addr_mult2;
    logic [4:0] addr_rslt0;
    logic [4:0] addr_rslt1;
    logic [4:0] addr_layer;
    logic [4:0] addr_prio0;
    logic [4:0] addr_prio1;
    logic [4:0] addr_prio2;
    logic [4:0] addr_prio3;
    logic [4:0] addr_in2;
    logic [4:0] addr_in3;
    logic [4:0] addr_pal_page;
    logic [7:0] cpsb_id;
    logic       six_button;

    mmr_cfg_chain u_cfg (
        .clk, .reg_rst, .cfg_we, .cfg_data,
        .addr_id, .addr_mult1, .addr_mult2, .addr_rslt0, .addr_rslt1, .addr_layer,
        .addr_prio0, .addr_prio1, .addr_prio2, .addr_prio3,
        .addr_in2, .addr_in3, .addr_pal_page, .cpsb_id,
        .layer_mask0, .layer_mask1, .layer_mask2, .layer_mask3,
        .game, .bank_offset, .bank_mask,
        .cpu_speed, .six_button, .charger, .kabuki_en
    );

    cpsa_regs u_cpsa (
        .clk, .reg_rst, .pxl_cen, .ppu1_cs, .addr, .dsn, .cpu_dout,
        .vram_obj_base, .vram1_base, .vram2_base, .vram3_base, .vram_row_base, .pal_base,
        .hpos1, .hpos2, .hpos3, .vpos1, .vpos2, .vpos3,
        .hstar1, .hstar2, .vstar1, .vstar2, .row_offset, .ppu_ctrl,
        .pal_copy, .obj_dma_ok
    );

    cpsb_regs u_cpsb (
        .clk, .reg_rst, .ppu2_cs, .addr, .dsn, .cpu_dout,
        .addr_id, .addr_mult1, .addr_mult2, .addr_rslt0, .addr_rslt1, .addr_layer,
        .addr_prio0, .addr_prio1, .addr_prio2, .addr_prio3,
        .addr_in2, .addr_in3, .addr_pal_page, .cpsb_id, .six_button,
        .start_button, .coin_input, .joystick1, .joystick2, .joystick3, .joystick4,
        .mmr_dout, .layer_ctrl, .prio0, .prio1, .prio2, .prio3, .pal_page_en
    );

endmodule

// ==== cpsb_regs/cpsb_regs.sv ====
module cpsb_regs import mmr_pkg::*; (
    input  logic        clk,
    input  logic        reg_rst,
    input  logic        ppu2_cs,
    input  logic [4:0]  addr,
    input  logic [1:0]  dsn,
    input  logic [15:0] cpu_dout,
    input  logic [4:0]  addr_id,
    input  logic [4:0]  addr_mult1,
    input  logic [4:0]  addr_mult2,
    input  logic [4:0]  addr_rslt0,
    input  logic [4:0]  addr_rslt1,
    input  logic [4:0]  addr_layer,
    input  logic [4:0]  addr_prio0,
    input  logic [4:0]  addr_prio1,
    input  logic [4:0]  addr_prio2,
    input  logic [4:0]  addr_prio3,
    input  logic [4:0]  addr_in2,
    input  logic [4:0]  addr_in3,
    input  logic [4:0]  addr_pal_page,
    input  logic [7:0]  cpsb_id,
    input  logic        six_button,
    input  logic [3:0]  start_button,
    input  logic [3:0]  coin_input,
    input  logic [9:0]  joystick1,
    input  logic [9:0]  joystick2,
    input  logic [9:0]  joystick3,
    input  logic [9:0]  joystick4,
    output logic [15:0] mmr_dout,
    output layer_ctrl_u layer_ctrl,
    output logic [15:0] prio0,
    output logic [15:0] prio1,
    output logic [15:0] prio2,
    output logic [15:0] prio3,
    output logic [5:0]  pal_page_en     // palette pages to copy
);

    logic [15:0] mult1;
    logic [15:0] mult2;
    logic [15:0] rslt0;
    logic [15:0] rslt1;
    logic [7:0]  in2;
    logic [7:0]  in3;
    logic [5:0]  lo_hit;    // id, mult1, mult2, rslt0, rslt1, layer
    logic [6:0]  hi_hit;    // prio0..3, pal page, in2, in3
    logic [15:0] lo_val;
    logic [15:0] hi_val;
    logic [15:0] rd_val;
    logic        wr_en;

    assign lo_hit = {
        addr == addr_layer,
        addr == addr_rslt1 && addr_rslt1 != ADDR_DISABLED_HI,
        addr == addr_rslt0 && addr_rslt0 != ADDR_DISABLED_HI,
        addr == addr_mult2 && addr_mult2 != ADDR_DISABLED_HI,
        addr == addr_mult1 && addr_mult1 != ADDR_DISABLED_HI,
        addr == addr_id
    };
    assign hi_hit = {
        addr == addr_in3 && addr_in3 != ADDR_DISABLED_LO,
        addr == addr_in2 && addr_in2 != ADDR_DISABLED_LO,
        addr == addr_pal_page,
        addr == addr_prio3 && addr_prio3 != ADDR_DISABLED_HI,
        addr == addr_prio2 && addr_prio2 != ADDR_DISABLED_HI,
        addr == addr_prio1 && addr_prio1 != ADDR_DISABLED_HI,
        addr == addr_prio0 && addr_prio0 != ADDR_DISABLED_HI
    };

    assign wr_en = ppu2_cs && dsn == 2'b00;

    always_comb begin
        lo_val = READ_IDLE;     // also covers a double match
        hi_val = READ_IDLE;
        case (lo_hit)
            6'b000001: lo_val = {4'd0, cpsb_id[7:4], 4'd0, cpsb_id[3:0]};
            6'b000010: lo_val = mult1;
            6'b000100: lo_val = mult2;
            6'b001000: lo_val = rslt0;
            6'b010000: lo_val = rslt1;
            6'b100000: lo_val = layer_ctrl.raw;
            default: ;
        endcase
        case (hi_hit)
            7'b0000001: hi_val = prio0;
            7'b0000010: hi_val = prio1;
            7'b0000100: hi_val = prio2;
            7'b0001000: hi_val = prio3;
            7'b0010000: hi_val = {10'd0, pal_page_en};
            7'b0100000: hi_val = {in2, in2};
            7'b1000000: hi_val = {in3, in3};
            default: ;
        endcase
        if (&addr)
            rd_val = READ_IDLE;
        else
            rd_val = $onehot(lo_hit) ? lo_val : hi_val;    // low group first
    end

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            mult1          <= '0;
            mult2          <= '0;
            prio0          <= '0;
            prio1          <= '0;
            prio2          <= '0;
            prio3          <= '0;
            layer_ctrl.raw <= LAYER_CTRL_RST;
            pal_page_en    <= PAL_PAGE_RST;
            mmr_dout       <= READ_IDLE;
        end else if (ppu2_cs) begin
            mmr_dout <= rd_val;
            if (wr_en) begin
                if (lo_hit[1]) mult1          <= cpu_dout;
                if (lo_hit[2]) mult2          <= cpu_dout;
                if (lo_hit[5]) layer_ctrl.raw <= cpu_dout;
                if (hi_hit[0]) prio0          <= cpu_dout;
                if (hi_hit[1]) prio1          <= cpu_dout;
                if (hi_hit[2]) prio2          <= cpu_dout;
                if (hi_hit[3]) prio3          <= cpu_dout;
                if (hi_hit[4]) pal_page_en    <= cpu_dout[5:0];
            end
        end
    end

    // product lands one cycle after the operands
    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst)
            {rslt1, rslt0} <= '0;
        else
            {rslt1, rslt0} <= 32'(mult1) * 32'(mult2);
    end

    // extra player inputs, sampled every cycle
    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            in2 <= '0;
            in3 <= '0;
        end else begin
            in3 <= {start_button[3], coin_input[3], joystick4[5:0]};
            if (six_button)
                in2 <= {1'b1, joystick2[9:7], 1'b1, joystick1[9:7]};
            else
                in2 <= {start_button[2], coin_input[2], joystick3[5:0]};  // player 3
        end
    end

    a_dout_hold: assert property (@(posedge clk) disable iff (reg_rst)
        !ppu2_cs |=> $stable(mmr_dout));

endmodule

// ==== cpsa_regs/cpsa_regs.sv ====
module cpsa_regs import mmr_pkg::*; (
    input  logic        clk,
    input  logic        reg_rst,
    input  logic        pxl_cen,
    input  logic        ppu1_cs,
    input  logic [4:0]  addr,
    input  logic [1:0]  dsn,            // byte strobes, active low
    input  logic [15:0] cpu_dout,
    output logic [15:0] vram_obj_base,
    output logic [15:0] vram1_base,
    output logic [15:0] vram2_base,
    output logic [15:0] vram3_base,
    output logic [15:0] vram_row_base,
    output logic [15:0] pal_base,
    output logic [15:0] hpos1,
    output logic [15:0] hpos2,
    output logic [15:0] hpos3,
    output logic [15:0] vpos1,
    output logic [15:0] vpos2,
    output logic [15:0] vpos3,
    output logic [15:0] hstar1,
    output logic [15:0] hstar2,
    output logic [15:0] vstar1,
    output logic [15:0] vstar2,
    output logic [15:0] row_offset,
    output logic [15:0] ppu_ctrl,
    output logic        pal_copy,
    output logic        obj_dma_ok
);

    logic wr_en;
    logic release_en;
    logic pre_copy;     // palette copy armed
    logic pre_dma_ok;   // object table copy armed

    assign wr_en      = ppu1_cs && dsn == 2'b00;   // full words only
    assign release_en = !ppu1_cs && pxl_cen;

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            vram_obj_base <= '0;
            vram1_base    <= '0;
            vram2_base    <= '0;
            vram3_base    <= '0;
            vram_row_base <= '0;
            pal_base      <= '0;
            hpos1         <= '0;
            hpos2         <= '0;
            hpos3         <= '0;
            vpos1         <= '0;
            vpos2         <= '0;
            vpos3         <= '0;
            hstar1        <= '0;
            hstar2        <= '0;
            vstar1        <= '0;
            vstar2        <= '0;
            row_offset    <= '0;
            ppu_ctrl      <= '0;
            pal_copy      <= 1'b0;
            obj_dma_ok    <= 1'b0;
            pre_copy      <= 1'b0;
            pre_dma_ok    <= 1'b0;
        end else begin
            // the base registers settle while cs is high, so the copy waits for cs low
            if (release_en) begin
                pal_copy   <= pre_copy;
                pre_copy   <= 1'b0;
                obj_dma_ok <= pre_dma_ok;
                pre_dma_ok <= 1'b0;
            end
            if (wr_en) begin
                case (addr)
                    CPSA_OBJ_BASE: begin
                        vram_obj_base <= cpu_dout;
                        pre_dma_ok    <= 1'b1;
                    end
                    CPSA_VRAM1_BASE: vram1_base    <= cpu_dout;
                    CPSA_VRAM2_BASE: vram2_base    <= cpu_dout;
                    CPSA_VRAM3_BASE: vram3_base    <= cpu_dout;
                    CPSA_ROW_BASE:   vram_row_base <= cpu_dout;
                    CPSA_PAL_BASE: begin
                        pal_base <= cpu_dout;
                        pre_copy <= 1'b1;
                    end
                    CPSA_HPOS1:      hpos1      <= cpu_dout;
                    CPSA_VPOS1:      vpos1      <= cpu_dout;
                    CPSA_HPOS2:      hpos2      <= cpu_dout;
                    CPSA_VPOS2:      vpos2      <= cpu_dout;
                    CPSA_HPOS3:      hpos3      <= cpu_dout;
                    CPSA_VPOS3:      vpos3      <= cpu_dout;
                    CPSA_HSTAR1:     hstar1     <= cpu_dout;
                    CPSA_VSTAR1:     vstar1     <= cpu_dout;
                    CPSA_HSTAR2:     hstar2     <= cpu_dout;
                    CPSA_VSTAR2:     vstar2     <= cpu_dout;
                    CPSA_ROW_OFFSET: row_offset <= cpu_dout;
                    CPSA_PPU_CTRL:   ppu_ctrl   <= cpu_dout;
                    default: ;                  // unmapped index
                endcase
            end
        end
    end

    // strobes come only from an armed request released with cs low on a pixel enable
    a_pal_copy_rise: assert property (@(posedge clk) disable iff (reg_rst)
        $rose(pal_copy) |-> $past(pre_copy && !ppu1_cs && pxl_cen));
    a_obj_dma_rise: assert property (@(posedge clk) disable iff (reg_rst)
        $rose(obj_dma_ok) |-> $past(pre_dma_ok && !ppu1_cs && pxl_cen));

endmodule

// ==== design/mmr_cfg_chain.sv ====
module mmr_cfg_chain import mmr_pkg::*; (
    input  logic        clk,
    input  logic        reg_rst,
    input  logic        cfg_we,
    input  logic [7:0]  cfg_data,
    output logic [4:0]  addr_id,
    output logic [4:0]  addr_mult1,
    output logic [4:0]  addr_mult2,
    output logic [4:0]  addr_rslt0,
    output logic [4:0]  addr_rslt1,
    output logic [4:0]  addr_layer,
    output logic [4:0]  addr_prio0,
    output logic [4:0]  addr_prio1,
    output logic [4:0]  addr_prio2,
    output logic [4:0]  addr_prio3,
    output logic [4:0]  addr_in2,
    output logic [4:0]  addr_in3,
    output logic [4:0]  addr_pal_page,
    output logic [7:0]  cpsb_id,
    output logic [7:0]  layer_mask0,
    output logic [7:0]  layer_mask1,
    output logic [7:0]  layer_mask2,
    output logic [7:0]  layer_mask3,
    output logic [7:0]  game,
    output logic [15:0] bank_offset,
    output logic [15:0] bank_mask,
    output logic        cpu_speed,
    output logic        six_button,
    output logic        charger,
    output logic        kabuki_en
);

    logic [8*CFG_BYTES-1:0] chain;
    logic                   last_cfg_we;
    logic                   cfg_edge;
    logic [7:0]             flags;

    function automatic logic [7:0] cfg_byte(input int idx);
        return chain[8*idx +: 8];
    endfunction

    // byte address in the chain, word index sits in bits 5:1
    function automatic logic [4:0] cfg_addr(input int idx);
        return chain[8*idx+1 +: 5];
    endfunction

    // edge capture lets the loader run from a slower clock
    assign cfg_edge = cfg_we && !last_cfg_we;

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            chain       <= '0;
            last_cfg_we <= 1'b0;
        end else begin
            last_cfg_we <= cfg_we;
            if (cfg_edge)
                chain <= {cfg_data, chain[8*CFG_BYTES-1:8]};  // new byte on top
        end
    end

    assign addr_id       = cfg_addr(CFG_ADDR_ID);
    assign addr_mult1    = cfg_addr(CFG_ADDR_MULT1);
    assign addr_mult2    = cfg_addr(CFG_ADDR_MULT2);
    assign addr_rslt0    = cfg_addr(CFG_ADDR_RSLT0);
    assign addr_rslt1    = cfg_addr(CFG_ADDR_RSLT1);
    assign addr_layer    = cfg_addr(CFG_ADDR_LAYER);
    assign addr_prio0    = cfg_addr(CFG_ADDR_PRIO0);
    assign addr_prio1    = cfg_addr(CFG_ADDR_PRIO1);
    assign addr_prio2    = cfg_addr(CFG_ADDR_PRIO2);
    assign addr_prio3    = cfg_addr(CFG_ADDR_PRIO3);
    assign addr_in2      = cfg_addr(CFG_ADDR_IN2);
    assign addr_in3      = cfg_addr(CFG_ADDR_IN3);
    assign addr_pal_page = cfg_addr(CFG_ADDR_PAL_PAGE);
    assign cpsb_id       = cfg_byte(CFG_ID);
    assign layer_mask0   = cfg_byte(CFG_MASK0);
    assign layer_mask1   = cfg_byte(CFG_MASK1);
    assign layer_mask2   = cfg_byte(CFG_MASK2);
    assign layer_mask3   = cfg_byte(CFG_MASK3);

    // mapper and board fields
    assign game        = cfg_byte(CFG_GAME);
    assign bank_offset = {cfg_byte(CFG_BANK_OFS + 1), cfg_byte(CFG_BANK_OFS)};
    assign bank_mask   = {cfg_byte(CFG_BANK_MASK + 1), cfg_byte(CFG_BANK_MASK)};
    assign flags       = cfg_byte(CFG_FLAGS);
    assign cpu_speed   = flags[FLAG_CPU_SPEED];     // 0 slow cpu, 1 fast cpu
    assign six_button  = flags[FLAG_SIX_BUTTON];
    assign charger     = flags[FLAG_CHARGER];
    assign kabuki_en   = flags[FLAG_KABUKI];

    // a held cfg_we or a glitch-free idle line must never move the chain
    a_chain_hold: assert property (@(posedge clk) disable iff (reg_rst)
        !cfg_edge |=> $stable(chain));

endmodule

// ==== common/mmr_pkg.sv ====
package mmr_pkg;

    localparam int CFG_BYTES = 24;          // configuration chain length in bytes

    // chain byte positions, address bytes hold a byte address
    localparam int CFG_ADDR_ID       = 0;
    localparam int CFG_ID            = 1;   // one nibble per read byte
    localparam int CFG_ADDR_MULT1    = 2;
    localparam int CFG_ADDR_MULT2    = 3;
    localparam int CFG_ADDR_RSLT0    = 4;
    localparam int CFG_ADDR_RSLT1    = 5;
    localparam int CFG_ADDR_LAYER    = 6;
    localparam int CFG_ADDR_PRIO0    = 7;
    localparam int CFG_ADDR_PRIO1    = 8;
    localparam int CFG_ADDR_PRIO2    = 9;
    localparam int CFG_ADDR_PRIO3    = 10;
    localparam int CFG_ADDR_IN2      = 11;
    localparam int CFG_ADDR_IN3      = 12;
    localparam int CFG_ADDR_PAL_PAGE = 13;
    localparam int CFG_MASK0         = 14;
    localparam int CFG_MASK1         = 15;
    localparam int CFG_MASK2         = 16;
    localparam int CFG_MASK3         = 17;
    localparam int CFG_GAME          = 18;
    localparam int CFG_BANK_OFS      = 19;  // two bytes, low first
    localparam int CFG_BANK_MASK     = 21;  // two bytes, low first
    localparam int CFG_FLAGS         = 23;

    // bits of the flags byte
    localparam int FLAG_CPU_SPEED  = 0;
    localparam int FLAG_SIX_BUTTON = 3;
    localparam int FLAG_CHARGER    = 4;
    localparam int FLAG_KABUKI     = 5;

    // fixed map of the video-control chip, word indexes
    localparam logic [4:0] CPSA_OBJ_BASE   = 5'h00;
    localparam logic [4:0] CPSA_VRAM1_BASE = 5'h01;
    localparam logic [4:0] CPSA_VRAM2_BASE = 5'h02;
    localparam logic [4:0] CPSA_VRAM3_BASE = 5'h03;
    localparam logic [4:0] CPSA_ROW_BASE   = 5'h04;
    localparam logic [4:0] CPSA_PAL_BASE   = 5'h05;
    localparam logic [4:0] CPSA_HPOS1      = 5'h06;
    localparam logic [4:0] CPSA_VPOS1      = 5'h07;
    localparam logic [4:0] CPSA_HPOS2      = 5'h08;
    localparam logic [4:0] CPSA_VPOS2      = 5'h09;
    localparam logic [4:0] CPSA_HPOS3      = 5'h0a;
    localparam logic [4:0] CPSA_VPOS3      = 5'h0b;
    localparam logic [4:0] CPSA_HSTAR1     = 5'h0c;
    localparam logic [4:0] CPSA_VSTAR1     = 5'h0d;
    localparam logic [4:0] CPSA_HSTAR2     = 5'h0e;
    localparam logic [4:0] CPSA_VSTAR2     = 5'h0f;
    localparam logic [4:0] CPSA_ROW_OFFSET = 5'h10;
    localparam logic [4:0] CPSA_PPU_CTRL   = 5'h11;

    localparam logic [4:0]  ADDR_DISABLED_HI = 5'h1f;  // mult and prio off
    localparam logic [4:0]  ADDR_DISABLED_LO = 5'h00;  // input ports off
    localparam logic [15:0] READ_IDLE        = 16'hffff;

    typedef struct packed {
        logic [1:0] rsvd;
        logic [1:0] order3;     // back-most layer
        logic [1:0] order2;
        logic [1:0] order1;
        logic [1:0] order0;     // front-most layer
        logic [5:0] enable;
    } layer_fields_t;

    typedef union packed {
        logic [15:0]   raw;     // cpu view
        layer_fields_t f;       // video view
    } layer_ctrl_u;

    localparam logic [15:0] LAYER_CTRL_RST = {2'b00, 2'd3, 2'd2, 2'd1, 2'd0, 6'd0};
    localparam logic [5:0]  PAL_PAGE_RST   = 6'h3f;

endpackage
